//--- hdl/act_buf_pkg.sv
// Activation buffer package with the sizes, register map and status bit positions
`default_nettype none

package act_buf_pkg;

    // ------------------------------
    // Data sizes
    // ------------------------------
    localparam int ACT_W      = 8;
    localparam int EXT_W      = 32;
    localparam int LINE_W     = 256;
    localparam int BEATS      = 8;
    localparam int BEAT_IDX_W = 3;

    // ------------------------------
    // Buffer depth and pointers
    // ------------------------------
    localparam int LINES = 32;
    localparam int PTR_W = 5;
    // One bit wider than a pointer so a full buffer counts as 32
    localparam int CNT_W = 6;

    // ------------------------------
    // Register block
    // ------------------------------
    localparam int REG_ADDR_W = 2;
    localparam int REG_W      = 32;

    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_COUNT  = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_HEAD   = 2'd2;
    localparam logic [REG_ADDR_W-1:0] REG_TAIL   = 2'd3;

    // Status word bits on read
    localparam int ST_EMPTY     = 0;
    localparam int ST_FULL      = 1;
    localparam int ST_OVERFLOW  = 2;
    localparam int ST_UNDERFLOW = 3;
    localparam int ST_MIX       = 4;

    // Command bits on a write to the status address
    localparam int CMD_CLR_ERR = 0;
    localparam int CMD_FLUSH   = 1;

endpackage

`default_nettype wire

//--- hdl/act_line_ram.sv
// Activation line memory with a beat write port, a line write port and a registered read
`default_nettype none

module act_line_ram (
    input  wire logic                                clk,
    input  wire logic                                nrst,

    // Beat-wide write, one external slice of a line
    input  wire logic                                bwr_en_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]       bwr_addr_i,
    input  wire logic [act_buf_pkg::BEAT_IDX_W-1:0]  bwr_beat_i,
    input  wire logic [act_buf_pkg::EXT_W-1:0]       bwr_data_i,

    // Line-wide write
    input  wire logic                                lwr_en_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]       lwr_addr_i,
    input  wire logic [act_buf_pkg::LINE_W-1:0]      lwr_data_i,

    // Registered line read
    input  wire logic                                rd_en_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]       rd_addr_i,
    output      logic [act_buf_pkg::LINE_W-1:0]      rd_data_o
);

    logic [act_buf_pkg::LINE_W-1:0] mem [act_buf_pkg::LINES];

    // ------------------------------
    // Write ports
    // ------------------------------

    // Line port comes second so it wins on a shared address
    always_ff @(posedge clk) begin
        if (bwr_en_i) begin
            mem[bwr_addr_i][bwr_beat_i*act_buf_pkg::EXT_W +: act_buf_pkg::EXT_W] <= bwr_data_i;
        end
        if (lwr_en_i) begin
            mem[lwr_addr_i] <= lwr_data_i;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Holds the last line read until the next read
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/act_fifo_ctrl.sv
// Activation FIFO controller for pointers, beat counters, occupancy and strobe arbitration
`default_nettype none

module act_fifo_ctrl (
    input  wire logic                                clk,
    input  wire logic                                nrst,

    input  wire logic                                ext_wr_en_i,
    input  wire logic                                int_wr_en_i,
    input  wire logic                                ext_rd_en_i,
    input  wire logic                                int_rd_en_i,
    input  wire logic                                flush_i,

    // Memory control
    output      logic                                bwr_en_o,
    output      logic                                lwr_en_o,
    output      logic [act_buf_pkg::PTR_W-1:0]       wr_addr_o,
    output      logic [act_buf_pkg::BEAT_IDX_W-1:0]  wr_beat_o,
    output      logic                                rd_en_o,
    output      logic [act_buf_pkg::PTR_W-1:0]       rd_addr_o,
    output      logic [act_buf_pkg::BEAT_IDX_W-1:0]  rd_beat_o,

    // Status
    output      logic [act_buf_pkg::CNT_W-1:0]       count_o,
    output      logic [act_buf_pkg::PTR_W-1:0]       head_o,
    output      logic [act_buf_pkg::PTR_W-1:0]       tail_o,
    output      logic                                full_o,
    output      logic                                empty_o,

    // Error events, one pulse per refused or dropped strobe
    output      logic                                ovf_o,
    output      logic                                unf_o,
    output      logic                                mix_o
);

    localparam logic [act_buf_pkg::BEAT_IDX_W-1:0] LAST_BEAT =
        act_buf_pkg::BEAT_IDX_W'(act_buf_pkg::BEATS - 1);

    logic [act_buf_pkg::BEAT_IDX_W-1:0] wr_beat;
    logic [act_buf_pkg::BEAT_IDX_W-1:0] rd_beat;
    logic                               iw, ew, ir, er;
    logic                               wr_line_start, rd_line_start;
    logic                               int_wr_ok, ext_wr_ok;
    logic                               int_rd_ok, ext_rd_ok;
    logic                               head_adv, tail_adv;

    // ------------------------------
    // Arbitration
    // ------------------------------

    // Strobes in a flush cycle are ignored entirely
    assign iw = int_wr_en_i & ~flush_i;
    assign ew = ext_wr_en_i & ~flush_i;
    assign ir = int_rd_en_i & ~flush_i;
    assign er = ext_rd_en_i & ~flush_i;

    assign wr_line_start = (wr_beat == '0);
    assign rd_line_start = (rd_beat == '0);

    // Internal side wins, external strobe dropped when both are high
    assign int_wr_ok = iw & wr_line_start & ~full_o;
    assign ext_wr_ok = ew & ~iw & ~(wr_line_start & full_o);
    assign int_rd_ok = ir & rd_line_start & ~empty_o;
    assign ext_rd_ok = er & ~ir & ~(rd_line_start & empty_o);

    assign head_adv = int_wr_ok | (ext_wr_ok & (wr_beat == LAST_BEAT));
    assign tail_adv = int_rd_ok | (ext_rd_ok & (rd_beat == LAST_BEAT));

    // Partial line implies count below full, so refusal causes never overlap
    assign ovf_o = (iw | ew) & wr_line_start & full_o;
    assign unf_o = (ir | er) & rd_line_start & empty_o;
    assign mix_o = (iw & ew) | (ir & er) | (iw & ~wr_line_start) | (ir & ~rd_line_start);

    // Memory control
    assign bwr_en_o  = ext_wr_ok;
    assign lwr_en_o  = int_wr_ok;
    assign wr_addr_o = head_o;
    assign wr_beat_o = wr_beat;
    assign rd_en_o   = int_rd_ok | ext_rd_ok;
    assign rd_addr_o = tail_o;
    assign rd_beat_o = rd_beat;

    assign full_o  = (count_o == act_buf_pkg::CNT_W'(act_buf_pkg::LINES));
    assign empty_o = (count_o == '0);

    // ------------------------------
    // State
    // ------------------------------
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            head_o  <= '0;
            tail_o  <= '0;
            wr_beat <= '0;
            rd_beat <= '0;
            count_o <= '0;
        end else if (flush_i) begin
            head_o  <= '0;
            tail_o  <= '0;
            wr_beat <= '0;
            rd_beat <= '0;
            count_o <= '0;
        end else begin
            if (ext_wr_ok) begin
                wr_beat <= wr_beat + 1'b1;
            end
            if (ext_rd_ok) begin
                rd_beat <= rd_beat + 1'b1;
            end
            if (head_adv) begin
                head_o <= head_o + 1'b1;
            end
            if (tail_adv) begin
                tail_o <= tail_o + 1'b1;
            end
            // Count only moves on whole lines
            case ({head_adv, tail_adv})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/act_buf_regs.sv
// Activation buffer register block with status readback, sticky errors and flush command
`default_nettype none

module act_buf_regs (
    input  wire logic                                clk,
    input  wire logic                                nrst,

    // Register access
    input  wire logic                                reg_wr_i,
    input  wire logic                                reg_rd_i,
    input  wire logic [act_buf_pkg::REG_ADDR_W-1:0]  reg_addr_i,
    input  wire logic [act_buf_pkg::REG_W-1:0]       reg_wdata_i,

    // Controller status
    input  wire logic [act_buf_pkg::CNT_W-1:0]       count_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]       head_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]       tail_i,
    input  wire logic                                full_i,
    input  wire logic                                empty_i,

    // Controller events
    input  wire logic                                ovf_i,
    input  wire logic                                unf_i,
    input  wire logic                                mix_i,

    output      logic [act_buf_pkg::REG_W-1:0]       reg_rdata_o,
    output      logic                                flush_o
);

    logic                            status_wr;
    logic                            clr_err;
    logic                            ovf_q, unf_q, mix_q;
    logic [act_buf_pkg::REG_W-1:0]   status_word;
    logic [act_buf_pkg::REG_W-1:0]   rd_mux;

    assign status_wr = reg_wr_i & (reg_addr_i == act_buf_pkg::REG_STATUS);
    assign clr_err   = status_wr & reg_wdata_i[act_buf_pkg::CMD_CLR_ERR];

    // ------------------------------
    // Sticky error flags
    // ------------------------------

    // A new event beats a clear in the same cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ovf_q   <= 1'b0;
            unf_q   <= 1'b0;
            mix_q   <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            ovf_q   <= (ovf_q & ~clr_err) | ovf_i;
            unf_q   <= (unf_q & ~clr_err) | unf_i;
            mix_q   <= (mix_q & ~clr_err) | mix_i;
            flush_o <= status_wr & reg_wdata_i[act_buf_pkg::CMD_FLUSH];
        end
    end

    // ------------------------------
    // Readback
    // ------------------------------
    always_comb begin
        status_word = '0;
        status_word[act_buf_pkg::ST_EMPTY]     = empty_i;
        status_word[act_buf_pkg::ST_FULL]      = full_i;
        status_word[act_buf_pkg::ST_OVERFLOW]  = ovf_q;
        status_word[act_buf_pkg::ST_UNDERFLOW] = unf_q;
        status_word[act_buf_pkg::ST_MIX]       = mix_q;

        case (reg_addr_i)
            act_buf_pkg::REG_COUNT: rd_mux = act_buf_pkg::REG_W'(count_i);
            act_buf_pkg::REG_HEAD:  rd_mux = act_buf_pkg::REG_W'(head_i);
            act_buf_pkg::REG_TAIL:  rd_mux = act_buf_pkg::REG_W'(tail_i);
            default:                rd_mux = status_word;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- hdl/activation_buffer.sv
// Activation buffer top with line FIFO, external beat and internal line ports, registers
`default_nettype none

module activation_buffer (
    input  wire logic                                clk,
    input  wire logic                                nrst,

    // External beat side
    input  wire logic [act_buf_pkg::EXT_W-1:0]       ext_wr_data_i,
    input  wire logic                                ext_wr_en_i,
    output      logic [act_buf_pkg::EXT_W-1:0]       ext_rd_data_o,
    input  wire logic                                ext_rd_en_i,

    // Internal line side
    input  wire logic [act_buf_pkg::LINE_W-1:0]      int_wr_data_i,
    input  wire logic                                int_wr_en_i,
    output      logic [act_buf_pkg::LINE_W-1:0]      int_rd_data_o,
    input  wire logic                                int_rd_en_i,

    // Register access
    input  wire logic                                reg_wr_i,
    input  wire logic                                reg_rd_i,
    input  wire logic [act_buf_pkg::REG_ADDR_W-1:0]  reg_addr_i,
    input  wire logic [act_buf_pkg::REG_W-1:0]       reg_wdata_i,
    output      logic [act_buf_pkg::REG_W-1:0]       reg_rdata_o,

    // Debug snoops
    output      logic [act_buf_pkg::PTR_W-1:0]       ofmap_head_snoop_o,
    output      logic [act_buf_pkg::PTR_W-1:0]       ifmap_head_snoop_o
);

    // ------------------------------
    // Signals
    // ------------------------------
    logic                               bwr_en, lwr_en, rd_en, flush;
    logic [act_buf_pkg::PTR_W-1:0]      wr_addr, rd_addr, head, tail;
    logic [act_buf_pkg::BEAT_IDX_W-1:0] wr_beat, rd_beat, rd_beat_q;
    logic [act_buf_pkg::CNT_W-1:0]      count;
    logic                               full, empty, ovf, unf, mix;
    logic [act_buf_pkg::LINE_W-1:0]     rd_line;

    act_fifo_ctrl u_ctrl (
        .clk(clk), .nrst(nrst),
        .ext_wr_en_i(ext_wr_en_i), .int_wr_en_i(int_wr_en_i),
        .ext_rd_en_i(ext_rd_en_i), .int_rd_en_i(int_rd_en_i), .flush_i(flush),
        .bwr_en_o(bwr_en), .lwr_en_o(lwr_en), .wr_addr_o(wr_addr), .wr_beat_o(wr_beat),
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_beat_o(rd_beat),
        .count_o(count), .head_o(head), .tail_o(tail), .full_o(full), .empty_o(empty),
        .ovf_o(ovf), .unf_o(unf), .mix_o(mix)
    );

    act_line_ram u_ram (
        .clk(clk), .nrst(nrst),
        .bwr_en_i(bwr_en), .bwr_addr_i(wr_addr), .bwr_beat_i(wr_beat),
        .bwr_data_i(ext_wr_data_i),
        .lwr_en_i(lwr_en), .lwr_addr_i(wr_addr), .lwr_data_i(int_wr_data_i),
        .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_line)
    );

    act_buf_regs u_regs (
        .clk(clk), .nrst(nrst),
        .reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i),
        .count_i(count), .head_i(head), .tail_i(tail), .full_i(full), .empty_i(empty),
        .ovf_i(ovf), .unf_i(unf), .mix_i(mix),
        .reg_rdata_o(reg_rdata_o), .flush_o(flush)
    );

    // Beat index follows the line into the read register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_beat_q <= '0;
        end else if (rd_en) begin
            rd_beat_q <= rd_beat;
        end
    end

    assign int_rd_data_o      = rd_line;
    assign ext_rd_data_o      = rd_line[rd_beat_q*act_buf_pkg::EXT_W +: act_buf_pkg::EXT_W];
    assign ofmap_head_snoop_o = head;
    assign ifmap_head_snoop_o = tail;

endmodule

`default_nettype wire

//--- test/act_buf_checker.sv
// Activation buffer checker comparing DUT outputs with the reference model expectations
`default_nettype none

module act_buf_checker (
    input  wire logic                            clk,
    input  wire logic                            en_i,

    // DUT outputs
    input  wire logic [act_buf_pkg::LINE_W-1:0]  int_rd_data_i,
    input  wire logic [act_buf_pkg::EXT_W-1:0]   ext_rd_data_i,
    input  wire logic [act_buf_pkg::REG_W-1:0]   reg_rdata_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]   ofmap_snoop_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]   ifmap_snoop_i,

    // Model values for the edge that follows
    input  wire logic [act_buf_pkg::LINE_W-1:0]  exp_line_i,
    input  wire logic [act_buf_pkg::EXT_W-1:0]   exp_ext_i,
    input  wire logic [act_buf_pkg::REG_W-1:0]   exp_reg_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]   exp_head_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]   exp_tail_i,
    output      int                              errors_o
);

    logic [act_buf_pkg::LINE_W-1:0] line_q = '0;
    logic [act_buf_pkg::EXT_W-1:0]  ext_q = '0;
    logic [act_buf_pkg::REG_W-1:0]  reg_q = '0;
    logic [act_buf_pkg::PTR_W-1:0]  head_q = '0;
    logic [act_buf_pkg::PTR_W-1:0]  tail_q = '0;
    int                             errors = 0;
    int                             test_errors = 0;
    int                             checks = 0;
    int                             total_checks = 0;
    int                             tests = 0;

    assign errors_o = errors;

    // Expectations line up with the DUT one edge later
    always @(posedge clk) begin
        line_q <= exp_line_i;
        ext_q  <= exp_ext_i;
        reg_q  <= exp_reg_i;
        head_q <= exp_head_i;
        tail_q <= exp_tail_i;
    end

    task automatic compare(input string name, input logic [act_buf_pkg::LINE_W-1:0] got,
                           input logic [act_buf_pkg::LINE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0h exp %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (en_i) begin
            compare("int_rd_data_o", int_rd_data_i, line_q);
            compare("ext_rd_data_o", ext_rd_data_i, ext_q);
            compare("reg_rdata_o", reg_rdata_i, reg_q);
            compare("ofmap_head_snoop_o", ofmap_snoop_i, head_q);
            compare("ifmap_head_snoop_o", ifmap_snoop_i, tail_q);
        end
    end

    task automatic end_test(input string name);
        $display("test %-12s checks %0d errors %0d", name, checks, test_errors);
        tests++;
        total_checks += checks;
        checks = 0;
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("totals tests %0d checks %0d errors %0d", tests, total_checks, errors);
    endtask

endmodule

`default_nettype wire

//--- test/act_buf_asserts.sv
// Concurrent checks on the FIFO controller flags, occupancy and error event pulses
`default_nettype none

module act_buf_asserts (
    input  wire logic                           clk,
    input  wire logic                           nrst,
    input  wire logic                           ext_wr_en_i,
    input  wire logic                           int_wr_en_i,
    input  wire logic                           ext_rd_en_i,
    input  wire logic                           int_rd_en_i,
    input  wire logic [act_buf_pkg::CNT_W-1:0]  count_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]  head_i,
    input  wire logic [act_buf_pkg::PTR_W-1:0]  tail_i,
    input  wire logic                           full_i,
    input  wire logic                           empty_i,
    input  wire logic                           ovf_i,
    input  wire logic                           unf_i,
    input  wire logic                           mix_i
);

    int failures = 0;

    // Count runs in whole lines, so both flags sit where head meets tail
    a_flags_match_ptrs: assert property (@(posedge clk) disable iff (!nrst)
        (head_i == tail_i) == (full_i || empty_i))
        else begin
            $error("full or empty disagrees with the head and tail pointers");
            failures++;
        end

    a_count_in_range: assert property (@(posedge clk) disable iff (!nrst)
        count_i <= act_buf_pkg::LINES)
        else begin
            $error("count exceeds the buffer depth");
            failures++;
        end

    // A refused strobe leaves the line count as it was
    a_ovf_no_change: assert property (@(posedge clk) disable iff (!nrst)
        (ovf_i && !ext_rd_en_i && !int_rd_en_i) |=> $stable(count_i))
        else begin
            $error("overflow event but the count moved");
            failures++;
        end

    a_unf_no_change: assert property (@(posedge clk) disable iff (!nrst)
        (unf_i && !ext_wr_en_i && !int_wr_en_i) |=> $stable(count_i))
        else begin
            $error("underflow event but the count moved");
            failures++;
        end

    // Lone internal strobe on a partial line is refused
    a_mix_no_change: assert property (@(posedge clk) disable iff (!nrst)
        (mix_i && !ext_wr_en_i && !ext_rd_en_i && !(int_wr_en_i && int_rd_en_i))
        |=> $stable(count_i))
        else begin
            $error("mix event on a partial line but the count moved");
            failures++;
        end

endmodule

bind act_fifo_ctrl act_buf_asserts u_asserts (
    .clk(clk), .nrst(nrst),
    .ext_wr_en_i(ext_wr_en_i), .int_wr_en_i(int_wr_en_i),
    .ext_rd_en_i(ext_rd_en_i), .int_rd_en_i(int_rd_en_i),
    .count_i(count_o), .head_i(head_o), .tail_i(tail_o),
    .full_i(full_o), .empty_i(empty_o),
    .ovf_i(ovf_o), .unf_i(unf_o), .mix_i(mix_o)
);

`default_nettype wire

//--- test/tb_activation_buffer.sv
// Activation buffer testbench with seeded random traffic and a reference line FIFO model
`default_nettype none

module tb_activation_buffer;

    logic                                clk = 1'b0;
    logic                                nrst = 1'b0;
    logic [act_buf_pkg::EXT_W-1:0]       ext_wr_data = '0;
    logic [act_buf_pkg::LINE_W-1:0]      int_wr_data = '0;
    logic                                ext_wr_en = 1'b0;
    logic                                int_wr_en = 1'b0;
    logic                                ext_rd_en = 1'b0;
    logic                                int_rd_en = 1'b0;
    logic                                reg_wr = 1'b0;
    logic                                reg_rd = 1'b0;
    logic [act_buf_pkg::REG_ADDR_W-1:0]  reg_addr = '0;
    logic [act_buf_pkg::REG_W-1:0]       reg_wdata = '0;
    logic [act_buf_pkg::EXT_W-1:0]       ext_rd_data;
    logic [act_buf_pkg::LINE_W-1:0]      int_rd_data;
    logic [act_buf_pkg::REG_W-1:0]       reg_rdata;
    logic [act_buf_pkg::PTR_W-1:0]       ofmap_snoop;
    logic [act_buf_pkg::PTR_W-1:0]       ifmap_snoop;

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [act_buf_pkg::LINE_W-1:0]      m_q[$];
    logic [act_buf_pkg::LINE_W-1:0]      m_wline = '0;
    logic [act_buf_pkg::LINE_W-1:0]      m_line = '0;
    logic [act_buf_pkg::BEAT_IDX_W-1:0]  m_wbeat = '0;
    logic [act_buf_pkg::BEAT_IDX_W-1:0]  m_rbeat = '0;
    logic [act_buf_pkg::BEAT_IDX_W-1:0]  m_beat = '0;
    logic [act_buf_pkg::PTR_W-1:0]       m_head = '0;
    logic [act_buf_pkg::PTR_W-1:0]       m_tail = '0;
    logic                                m_ovf = 1'b0;
    logic                                m_unf = 1'b0;
    logic                                m_mix = 1'b0;
    logic                                m_flush = 1'b0;

    logic [act_buf_pkg::LINE_W-1:0]      exp_line = '0;
    logic [act_buf_pkg::EXT_W-1:0]       exp_ext = '0;
    logic [act_buf_pkg::REG_W-1:0]       exp_reg = '0;
    logic [act_buf_pkg::PTR_W-1:0]       exp_head = '0;
    logic [act_buf_pkg::PTR_W-1:0]       exp_tail = '0;
    logic                                chk_en = 1'b0;
    int                                  errors;

    activation_buffer activation_buffer_i (
        .clk(clk), .nrst(nrst),
        .ext_wr_data_i(ext_wr_data), .ext_wr_en_i(ext_wr_en),
        .ext_rd_data_o(ext_rd_data), .ext_rd_en_i(ext_rd_en),
        .int_wr_data_i(int_wr_data), .int_wr_en_i(int_wr_en),
        .int_rd_data_o(int_rd_data), .int_rd_en_i(int_rd_en),
        .reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_addr_i(reg_addr),
        .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
        .ofmap_head_snoop_o(ofmap_snoop), .ifmap_head_snoop_o(ifmap_snoop)
    );

    act_buf_checker u_chk (
        .clk(clk), .en_i(chk_en),
        .int_rd_data_i(int_rd_data), .ext_rd_data_i(ext_rd_data), .reg_rdata_i(reg_rdata),
        .ofmap_snoop_i(ofmap_snoop), .ifmap_snoop_i(ifmap_snoop),
        .exp_line_i(exp_line), .exp_ext_i(exp_ext), .exp_reg_i(exp_reg),
        .exp_head_i(exp_head), .exp_tail_i(exp_tail), .errors_o(errors)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [act_buf_pkg::LINE_W-1:0] rand_line();
        logic [act_buf_pkg::LINE_W-1:0] l;
        for (int i = 0; i < act_buf_pkg::BEATS; i++) begin
            l[i*act_buf_pkg::EXT_W +: act_buf_pkg::EXT_W] = $urandom;
        end
        return l;
    endfunction

    // ------------------------------
    // One clock of stimulus and model
    // ------------------------------
    task automatic step(input logic ew, input logic iw, input logic er, input logic ir,
                        input logic rw, input logic rr,
                        input logic [act_buf_pkg::REG_ADDR_W-1:0] ra,
                        input logic [act_buf_pkg::REG_W-1:0] rwd);
        logic [act_buf_pkg::EXT_W-1:0]  ewd;
        logic [act_buf_pkg::LINE_W-1:0] iwd;
        logic [act_buf_pkg::REG_W-1:0]  st;
        logic                           was_full;
        logic                           was_empty;
        logic                           ovf;
        logic                           unf;
        logic                           mix;
        logic                           status_wr;
        ewd = $urandom;
        iwd = rand_line();
        @(posedge clk);
        ext_wr_en   <= ew;
        ext_wr_data <= ewd;
        int_wr_en   <= iw;
        int_wr_data <= iwd;
        ext_rd_en   <= er;
        int_rd_en   <= ir;
        reg_wr      <= rw;
        reg_rd      <= rr;
        reg_addr    <= ra;
        reg_wdata   <= rwd;
        was_full  = (m_q.size() == act_buf_pkg::LINES);
        was_empty = (m_q.size() == 0);
        ovf = 1'b0;
        unf = 1'b0;
        mix = 1'b0;
        // Register reads return the state before this edge
        if (rr) begin
            st = '0;
            st[act_buf_pkg::ST_EMPTY]     = was_empty;
            st[act_buf_pkg::ST_FULL]      = was_full;
            st[act_buf_pkg::ST_OVERFLOW]  = m_ovf;
            st[act_buf_pkg::ST_UNDERFLOW] = m_unf;
            st[act_buf_pkg::ST_MIX]       = m_mix;
            case (ra)
                act_buf_pkg::REG_COUNT: exp_reg <= act_buf_pkg::REG_W'(m_q.size());
                act_buf_pkg::REG_HEAD:  exp_reg <= act_buf_pkg::REG_W'(m_head);
                act_buf_pkg::REG_TAIL:  exp_reg <= act_buf_pkg::REG_W'(m_tail);
                default:                exp_reg <= st;
            endcase
        end
        if (m_flush) begin
            m_q.delete();
            m_head  = '0;
            m_tail  = '0;
            m_wbeat = '0;
            m_rbeat = '0;
        end else begin
            // Read side, internal first
            if (ir) begin
                mix = mix | er | (m_rbeat != 0);
                if (m_rbeat == 0 && was_empty) begin
                    unf = 1'b1;
                end else if (m_rbeat == 0) begin
                    m_line = m_q.pop_front();
                    m_beat = '0;
                    m_tail = m_tail + 1'b1;
                end
            end else if (er) begin
                if (m_rbeat == 0 && was_empty) begin
                    unf = 1'b1;
                end else begin
                    m_line = m_q[0];
                    m_beat = m_rbeat;
                    if (m_rbeat == act_buf_pkg::BEATS - 1) begin
                        void'(m_q.pop_front());
                        m_tail = m_tail + 1'b1;
                    end
                    m_rbeat = m_rbeat + 1'b1;
                end
            end
            // Write side, internal first
            if (iw) begin
                mix = mix | ew | (m_wbeat != 0);
                if (m_wbeat == 0 && was_full) begin
                    ovf = 1'b1;
                end else if (m_wbeat == 0) begin
                    m_q.push_back(iwd);
                    m_head = m_head + 1'b1;
                end
            end else if (ew) begin
                if (m_wbeat == 0 && was_full) begin
                    ovf = 1'b1;
                end else begin
                    m_wline[m_wbeat*act_buf_pkg::EXT_W +: act_buf_pkg::EXT_W] = ewd;
                    if (m_wbeat == act_buf_pkg::BEATS - 1) begin
                        m_q.push_back(m_wline);
                        m_head = m_head + 1'b1;
                    end
                    m_wbeat = m_wbeat + 1'b1;
                end
            end
        end
        status_wr = rw && (ra == act_buf_pkg::REG_STATUS);
        m_ovf   = (m_ovf && !(status_wr && rwd[act_buf_pkg::CMD_CLR_ERR])) || ovf;
        m_unf   = (m_unf && !(status_wr && rwd[act_buf_pkg::CMD_CLR_ERR])) || unf;
        m_mix   = (m_mix && !(status_wr && rwd[act_buf_pkg::CMD_CLR_ERR])) || mix;
        m_flush = status_wr && rwd[act_buf_pkg::CMD_FLUSH];
        exp_line <= m_line;
        exp_ext  <= m_line[m_beat*act_buf_pkg::EXT_W +: act_buf_pkg::EXT_W];
        exp_head <= m_head;
        exp_tail <= m_tail;
    endtask

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic idle();
        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic read_reg(input logic [act_buf_pkg::REG_ADDR_W-1:0] addr);
        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, addr, '0);
    endtask

    task automatic read_all_regs();
        for (int a = 0; a < 4; a++) begin
            read_reg(act_buf_pkg::REG_ADDR_W'(a));
        end
    endtask

    task automatic write_cmd(input int bit_pos);
        logic [act_buf_pkg::REG_W-1:0] cmd;
        cmd = '0;
        cmd[bit_pos] = 1'b1;
        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, act_buf_pkg::REG_STATUS, cmd);
    endtask

    task automatic abort(input string why);
        $display("TIMEOUT at %0t: %s", $time, why);
        $display("Test failed");
        $finish;
    endtask

    // Whole lines in, finishing a partial external line first
    task automatic fill();
        int guard;
        guard = 0;
        while (m_q.size() < act_buf_pkg::LINES) begin
            if (guard == 300) begin
                abort("buffer did not fill within 300 cycles");
            end
            step(m_wbeat != 0, m_wbeat == 0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            guard++;
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (m_q.size() != 0) begin
            if (guard == 300) begin
                abort("buffer did not drain within 300 cycles");
            end
            step(1'b0, 1'b0, m_rbeat != 0, m_rbeat == 0, 1'b0, 1'b0, '0, '0);
            guard++;
        end
    endtask

    task automatic random_traffic(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            step(($urandom % 3) == 0, ($urandom % 6) == 0, ($urandom % 3) == 0,
                 ($urandom % 6) == 0, 1'b0, ($urandom % 4) == 0, 2'($urandom), '0);
        end
    endtask

    task automatic finish_test(input string name);
        idle();
        idle();
        u_chk.end_test(name);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        void'($urandom(32'hea28));
        repeat (4) @(posedge clk);
        nrst   <= 1'b1;
        chk_en <= 1'b1;

        for (int n = 0; n < 300; n++) begin
            step(1'b0, ($urandom % 2) == 0, 1'b0, ($urandom % 2) == 0, 1'b0, 1'b0, '0, '0);
        end
        drain();
        finish_test("int_order");

        // External beats in, internal line out, then the reverse
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < act_buf_pkg::BEATS; b++) begin
                step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
                if (($urandom % 3) == 0) begin
                    idle();
                end
            end
            step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
            step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            for (int b = 0; b < act_buf_pkg::BEATS; b++) begin
                step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
            end
        end
        finish_test("beat_line");

        fill();
        step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        read_reg(act_buf_pkg::REG_STATUS);
        read_reg(act_buf_pkg::REG_COUNT);
        write_cmd(act_buf_pkg::CMD_CLR_ERR);
        read_reg(act_buf_pkg::REG_STATUS);
        drain();
        step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
        read_reg(act_buf_pkg::REG_STATUS);
        write_cmd(act_buf_pkg::CMD_CLR_ERR);
        read_reg(act_buf_pkg::REG_STATUS);
        finish_test("full_empty");

        random_traffic(400);
        read_reg(act_buf_pkg::REG_STATUS);
        finish_test("mix_rules");

        random_traffic(200);
        read_all_regs();
        write_cmd(act_buf_pkg::CMD_FLUSH);
        // Strobes in the flush cycle must be ignored
        step(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, '0, '0);
        read_all_regs();
        random_traffic(60);
        read_all_regs();
        finish_test("regs_flush");

        u_chk.print_totals();
        if (errors == 0 && activation_buffer_i.u_ctrl.u_asserts.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/act_buf_pkg.sv
hdl/act_line_ram.sv
hdl/act_fifo_ctrl.sv
hdl/act_buf_regs.sv
hdl/activation_buffer.sv
test/act_buf_checker.sv
test/act_buf_asserts.sv
test/tb_activation_buffer.sv
